// File: hdl/tile_cfg.svh
`ifndef TILE_CFG_SVH
`define TILE_CFG_SVH

// tile geometry
`define TILE_SIDES_IN 4
`define TILE_SIDES_OUT 3
`define TILE_TRACKS 4

// config address fields
`define TILE_ID_LSB 0
`define TILE_ID_MSB 15
`define BLOCK_ID_LSB 16
`define BLOCK_ID_MSB 31

// config field widths
`define CB_SEL_W 3
`define SB_SEL_W 2
`define CLB_OP_W 2

// derived counts
`define CB_NUM_TRACKS (2 * `TILE_TRACKS)
`define SB_NUM_SEL (`TILE_SIDES_OUT * `TILE_TRACKS)

`endif

// File: hdl/tile_pkg.sv
`include "tile_cfg.svh"

package tile_pkg;

	typedef logic [`TILE_TRACKS-1:0] track_side_t;

	// incoming tracks, side0 in the low bits
	typedef struct packed {
		track_side_t side3;
		track_side_t side2;
		track_side_t side1;
		track_side_t side0;
	} tracks_in_t;

	// outgoing tracks, sides 0 to 2 only
	typedef struct packed {
		track_side_t side2;
		track_side_t side1;
		track_side_t side0;
	} tracks_out_t;

	typedef struct packed {
		logic valid; // one write per cycle
		logic [31:0] addr;
		logic [31:0] data;
	} config_bus_t;

	typedef struct packed {
		logic sb;
		logic cb0;
		logic cb1;
		logic clb;
	} cfg_strobe_t;

	typedef enum logic [`BLOCK_ID_MSB-`BLOCK_ID_LSB:0] {
		BLK_CLB = 16'd4,
		BLK_CB1 = 16'd5,
		BLK_CB0 = 16'd6,
		BLK_SB = 16'd7
	} block_id_e;

	typedef enum logic [`CLB_OP_W-1:0] {
		OP_AND = 2'd0,
		OP_OR = 2'd1,
		OP_XOR = 2'd2,
		OP_NAND = 2'd3
	} clb_op_e;

endpackage

// File: hdl/config_decode.sv
`timescale 1ns/10ps
`include "tile_cfg.svh"

module config_decode import tile_pkg::*; (
	input logic clk,
	input logic reset,
	input config_bus_t cfg,
	input logic [15:0] tile_id,
	output cfg_strobe_t strobe
);

	logic [`TILE_ID_MSB-`TILE_ID_LSB:0] addr_tile;
	logic [`BLOCK_ID_MSB-`BLOCK_ID_LSB:0] addr_block;
	logic tile_hit;

	assign addr_tile = cfg.addr[`TILE_ID_MSB:`TILE_ID_LSB];
	assign addr_block = cfg.addr[`BLOCK_ID_MSB:`BLOCK_ID_LSB];

	// write aimed at this tile
	assign tile_hit = cfg.valid && (addr_tile == tile_id);

	always_comb begin
		strobe = '0;
		if (tile_hit) begin
			case (addr_block)
				BLK_SB: begin
					strobe.sb = 1'b1;
				end
				BLK_CB0: begin
					strobe.cb0 = 1'b1;
				end
				BLK_CB1: begin
					strobe.cb1 = 1'b1;
				end
				BLK_CLB: begin
					strobe.clb = 1'b1;
				end
				default: begin
					strobe = '0; // unknown block, ignore
				end
			endcase
		end
	end

	// at most one block written per config cycle
	a_strobe_onehot: assert property (
		@(posedge clk) disable iff (reset)
		$onehot0(strobe)
	);

	// no write without the bus strobe
	a_strobe_needs_valid: assert property (
		@(posedge clk) disable iff (reset)
		!cfg.valid |-> (strobe == '0)
	);

endmodule

// File: hdl/connect_box.sv
`timescale 1ns/10ps
`include "tile_cfg.svh"

module connect_box (
	input logic clk,
	input logic reset,
	input logic cfg_en,
	input logic [31:0] cfg_data,
	input logic [`CB_NUM_TRACKS-1:0] tracks,
	output logic operand
);

	logic [`CB_SEL_W-1:0] sel;

	// track select from the low data bits
	always_ff @(posedge clk) begin
		if (reset) begin
			sel <= '0;
		end else if (cfg_en) begin
			sel <= cfg_data[`CB_SEL_W-1:0];
		end
	end

	// 0..3 incoming and 4..7 outgoing of the same side
	always_comb begin
		operand = tracks[sel];
	end

	a_sel_known: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(sel)
	);

endmodule

// File: hdl/logic_block.sv
`timescale 1ns/10ps
`include "tile_cfg.svh"

module logic_block import tile_pkg::*; (
	input logic clk,
	input logic reset,
	input logic cfg_en,
	input logic [31:0] cfg_data,
	input logic op0,
	input logic op1,
	output logic result
);

	clb_op_e opcode;
	logic result_next;

	always_ff @(posedge clk) begin
		if (reset) begin
			opcode <= OP_AND;
		end else if (cfg_en) begin
			opcode <= clb_op_e'(cfg_data[`CLB_OP_W-1:0]);
		end
	end

	always_comb begin
		case (opcode)
			OP_AND: begin
				result_next = op0 & op1;
			end
			OP_OR: begin
				result_next = op0 | op1;
			end
			OP_XOR: begin
				result_next = op0 ^ op1;
			end
			OP_NAND: begin
				result_next = ~(op0 & op1);
			end
			default: begin
				result_next = 1'b0;
			end
		endcase
	end

	// registered output also cuts the track loop
	always_ff @(posedge clk) begin
		if (reset) begin
			result <= 1'b0;
		end else begin
			result <= result_next;
		end
	end

	a_result_reset: assert property (
		@(posedge clk)
		reset |=> (result == 1'b0)
	);

	a_opcode_known: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(opcode)
	);

endmodule

// File: hdl/switch_box.sv
`timescale 1ns/10ps
`include "tile_cfg.svh"

module switch_box import tile_pkg::*; (
	input logic clk,
	input logic reset,
	input logic cfg_en,
	input logic [31:0] cfg_data,
	input tracks_in_t tracks_in,
	input logic pe_out,
	output tracks_out_t tracks_out
);

	localparam int NUM_SEL = `SB_NUM_SEL;
	localparam int SEL_BITS = NUM_SEL * `SB_SEL_W;

	logic [NUM_SEL-1:0][`SB_SEL_W-1:0] sel;
	track_side_t [`TILE_SIDES_IN-1:0] side_in;
	logic [NUM_SEL-1:0] out_flat;

	// n-th choice skips the output's own side
	function automatic int src_side(input int side, input int choice);
		int src;
		if (choice < side) begin
			src = choice;
		end else begin
			src = choice + 1;
		end
		return src;
	endfunction

	// all twelve fields written together
	always_ff @(posedge clk) begin
		if (reset) begin
			sel <= '0;
		end else if (cfg_en) begin
			sel <= cfg_data[SEL_BITS-1:0];
		end
	end

	assign side_in = tracks_in; // side0 in the low nibble

	generate
		for (genvar s = 0; s < `TILE_SIDES_OUT; s++) begin : g_side
			for (genvar t = 0; t < `TILE_TRACKS; t++) begin : g_track
				localparam int FIELD = s * `TILE_TRACKS + t;
				localparam int SRC0 = src_side(s, 0);
				localparam int SRC1 = src_side(s, 1);
				localparam int SRC2 = src_side(s, 2);

				logic route;

				always_comb begin
					case (sel[FIELD])
						2'd0: begin
							route = side_in[SRC0][t];
						end
						2'd1: begin
							route = side_in[SRC1][t];
						end
						2'd2: begin
							route = side_in[SRC2][t];
						end
						default: begin
							route = pe_out; // logic block result
						end
					endcase
				end

				assign out_flat[FIELD] = route;
			end
		end
	endgenerate

	assign tracks_out = tracks_out_t'(out_flat);

	a_sel_known: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(sel)
	);

endmodule

// File: hdl/pe_tile.sv
`timescale 1ns/10ps

module pe_tile import tile_pkg::*; (
	input logic clk,
	input logic reset,
	input config_bus_t cfg,
	input logic [15:0] tile_id,
	input tracks_in_t tracks_in,
	output tracks_out_t tracks_out
);

	cfg_strobe_t strobe;
	logic op0;
	logic op1;
	logic pe_out;

	config_decode decode (
		.clk(clk),
		.reset(reset),
		.cfg(cfg),
		.tile_id(tile_id),
		.strobe(strobe)
	);

	// operand 0 from side 0, outgoing tracks in the high half
	connect_box cb0 (
		.clk(clk),
		.reset(reset),
		.cfg_en(strobe.cb0),
		.cfg_data(cfg.data),
		.tracks({tracks_out.side0, tracks_in.side0}),
		.operand(op0)
	);

	// operand 1 from side 1
	connect_box cb1 (
		.clk(clk),
		.reset(reset),
		.cfg_en(strobe.cb1),
		.cfg_data(cfg.data),
		.tracks({tracks_out.side1, tracks_in.side1}),
		.operand(op1)
	);

	logic_block compute_block (
		.clk(clk),
		.reset(reset),
		.cfg_en(strobe.clb),
		.cfg_data(cfg.data),
		.op0(op0),
		.op1(op1),
		.result(pe_out)
	);

	switch_box sb (
		.clk(clk),
		.reset(reset),
		.cfg_en(strobe.sb),
		.cfg_data(cfg.data),
		.tracks_in(tracks_in),
		.pe_out(pe_out),
		.tracks_out(tracks_out)
	);

endmodule

// File: tests/clock_gen.sv
`timescale 1ns/10ps

module clock_gen (
	output logic clk,
	output logic reset
);

	localparam int HALF_PERIOD = 4;
	localparam int RESET_CYCLES = 16;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0; // released just after the edge
	end

endmodule

// File: tests/tile_tb.sv
`timescale 1ns/10ps

module tile_tb import tile_pkg::*; ();

	localparam logic [15:0] TILE_ID = 16'h3a5c;
	localparam logic [31:0] SEED = 32'ha139_9253;
	localparam int N_ITER = 8;
	localparam int N_TESTS = 5;
	localparam int CYC_PER_ITER = 32;
	localparam int RESET_CYCLES = 16;
	localparam int CLK_PERIOD = 8;
	localparam int TIMEOUT_NS = 2 * CLK_PERIOD * (RESET_CYCLES + N_TESTS * N_ITER * CYC_PER_ITER);

	logic clk;
	logic reset;
	config_bus_t cfg;
	logic [15:0] tile_id;
	tracks_in_t tracks_in;
	tracks_out_t tracks_out;

	// mirror of what has been written into the tile
	logic [1:0] sb_m [12];
	logic [2:0] cb_m [2];
	clb_op_e op_m;
	logic pe_m;
	int checks;
	int errors;

	clock_gen clk_gen (
		.clk(clk),
		.reset(reset)
	);

	pe_tile UUT (
		.clk(clk),
		.reset(reset),
		.cfg(cfg),
		.tile_id(tile_id),
		.tracks_in(tracks_in),
		.tracks_out(tracks_out)
	);

	// k-th incoming side in increasing order skipping side s
	function automatic int other_side(input int s, input int k);
		int n;
		int res;
		n = 0;
		res = 0;
		for (int i = 0; i < 4; i++) begin
			if (i != s) begin
				if (n == k) res = i;
				n++;
			end
		end
		return res;
	endfunction

	function automatic tracks_out_t route_tracks(input tracks_in_t tin, input logic pe);
		logic [15:0] tin_flat;
		logic [11:0] out_flat;
		int f;
		tin_flat = tin;
		for (int s = 0; s < 3; s++) begin
			for (int t = 0; t < 4; t++) begin
				f = s * 4 + t;
				if (sb_m[f] == 2'd3) out_flat[f] = pe;
				else out_flat[f] = tin_flat[4 * other_side(s, sb_m[f]) + t];
			end
		end
		return tracks_out_t'(out_flat);
	endfunction

	// cb idx selects from side idx with incoming tracks first
	function automatic logic pick_operand(input int idx, input tracks_in_t tin,
		input tracks_out_t tout);
		logic [15:0] tin_flat;
		logic [11:0] tout_flat;
		int sel;
		tin_flat = tin;
		tout_flat = tout;
		sel = cb_m[idx];
		if (sel < 4) return tin_flat[4 * idx + sel];
		return tout_flat[4 * idx + sel - 4];
	endfunction

	function automatic logic apply_op(input clb_op_e op, input logic a, input logic b);
		case (op)
			OP_AND: return a & b;
			OP_OR: return a | b;
			OP_XOR: return a ^ b;
			default: return ~(a & b);
		endcase
	endfunction

	// sides 0 and 1 take incoming tracks only so operands never loop through pe_out
	function automatic logic [31:0] random_sb_data(input bit pe_route);
		logic [31:0] d;
		d = '0;
		for (int f = 0; f < 12; f++) begin
			if (f < 8) d[2*f +: 2] = 2'($urandom % 3);
			else d[2*f +: 2] = 2'($urandom % 4);
		end
		if (pe_route) d[17:16] = 2'd3; // side 2 track 0
		return d;
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %s: expected %h, got %h", name, exp, act);
		end
	endtask

	// one clock with the pe_out model following the edge
	task automatic tick();
		logic pe_next;
		tracks_out_t tout;
		tout = route_tracks(tracks_in, pe_m);
		if (reset) pe_next = 1'b0;
		else pe_next = apply_op(op_m, pick_operand(0, tracks_in, tout),
			pick_operand(1, tracks_in, tout));
		@(posedge clk);
		pe_m = pe_next;
		#1;
	endtask

	task automatic write_cfg(input logic [15:0] tid, input logic [15:0] blk,
		input logic [31:0] data, input logic valid);
		tick();
		cfg.valid = valid;
		cfg.addr = {blk, tid};
		cfg.data = data;
		tick();
		cfg.valid = 1'b0;
		if (valid && tid == TILE_ID) begin
			case (blk)
				BLK_SB: for (int f = 0; f < 12; f++) sb_m[f] = data[2*f +: 2];
				BLK_CB0: cb_m[0] = data[2:0];
				BLK_CB1: cb_m[1] = data[2:0];
				BLK_CLB: op_m = clb_op_e'(data[1:0]);
				default: ; // not a block of this tile
			endcase
		end
	endtask

	task automatic drive_check();
		tick();
		tracks_in = tracks_in_t'(16'($urandom));
		#2;
		check("tracks_out", route_tracks(tracks_in, pe_m), tracks_out);
	endtask

	// result of the new operands shows on side 2 track 0 one cycle later
	task automatic pe_route_check();
		logic exp;
		tracks_out_t tout;
		tick();
		tracks_in = tracks_in_t'(16'($urandom));
		tout = route_tracks(tracks_in, pe_m);
		exp = apply_op(op_m, pick_operand(0, tracks_in, tout), pick_operand(1, tracks_in, tout));
		tick();
		#2;
		check("tracks_out.side2[0]", exp, tracks_out.side2[0]);
		check("tracks_out", route_tracks(tracks_in, pe_m), tracks_out);
	endtask

	task automatic report(input string name, input int err0);
		$display("%s finished, %0d errors", name, errors - err0);
	endtask

	task automatic reset_defaults();
		int err0;
		err0 = errors;
		for (int i = 0; i < N_ITER; i++) begin
			tick();
			tracks_in = tracks_in_t'(16'($urandom));
			#2;
			check("tracks_out.side0", tracks_in.side1, tracks_out.side0);
			check("tracks_out.side1", tracks_in.side0, tracks_out.side1);
			check("tracks_out.side2", tracks_in.side0, tracks_out.side2);
		end
		report("reset_defaults", err0);
	endtask

	task automatic switch_routing();
		int err0;
		err0 = errors;
		for (int i = 0; i < N_ITER; i++) begin
			write_cfg(TILE_ID, BLK_SB, $urandom & 32'h00ff_ffff, 1'b1);
			drive_check();
			drive_check();
		end
		report("switch_routing", err0);
	endtask

	task automatic operand_opcodes();
		int err0;
		err0 = errors;
		for (int i = 0; i < N_ITER; i++) begin
			write_cfg(TILE_ID, BLK_SB, random_sb_data(1'b1), 1'b1);
			write_cfg(TILE_ID, BLK_CB0, $urandom, 1'b1); // upper bits ignored by the box
			write_cfg(TILE_ID, BLK_CB1, $urandom, 1'b1);
			for (int k = 0; k < 4; k++) begin
				write_cfg(TILE_ID, BLK_CLB, ($urandom & ~32'h3) | k, 1'b1);
				pe_route_check();
			end
		end
		report("operand_opcodes", err0);
	endtask

	task automatic address_filter();
		int err0;
		logic [15:0] bad_blk;
		err0 = errors;
		write_cfg(TILE_ID, BLK_SB, random_sb_data(1'b1), 1'b1);
		for (int i = 0; i < N_ITER; i++) begin
			write_cfg(TILE_ID ^ 16'(1 + $urandom % 16'hffff), BLK_SB, $urandom, 1'b1);
			pe_route_check();
			if ($urandom % 2) bad_blk = 16'($urandom % 4);
			else bad_blk = 16'(8 + $urandom % 1000);
			write_cfg(TILE_ID, bad_blk, $urandom, 1'b1);
			pe_route_check();
			write_cfg(TILE_ID, BLK_SB, $urandom, 1'b0);
			pe_route_check();
		end
		report("address_filter", err0);
	endtask

	task automatic write_isolation();
		int err0;
		err0 = errors;
		write_cfg(TILE_ID, BLK_SB, random_sb_data(1'b1), 1'b1);
		for (int i = 0; i < N_ITER; i++) begin
			write_cfg(TILE_ID, BLK_CB0, $urandom, 1'b1);
			pe_route_check();
			write_cfg(TILE_ID, BLK_CB1, $urandom, 1'b1);
			pe_route_check();
			write_cfg(TILE_ID, BLK_CLB, $urandom, 1'b1);
			pe_route_check();
			write_cfg(TILE_ID, BLK_SB, random_sb_data(1'b1), 1'b1);
			pe_route_check();
		end
		report("write_isolation", err0);
	endtask

	initial begin
		#TIMEOUT_NS;
		$display("watchdog expired before the tests completed");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		cfg = '0;
		tile_id = TILE_ID;
		tracks_in = '0;
		checks = 0;
		errors = 0;
		for (int f = 0; f < 12; f++) sb_m[f] = 2'd0;
		cb_m[0] = 3'd0;
		cb_m[1] = 3'd0;
		op_m = OP_AND;
		pe_m = 1'b0;
		void'($urandom(SEED));
		@(negedge reset);
		reset_defaults();
		switch_routing();
		operand_opcodes();
		address_filter();
		write_isolation();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: files.f
+incdir+hdl
hdl/tile_pkg.sv
hdl/config_decode.sv
hdl/connect_box.sv
hdl/logic_block.sv
hdl/switch_box.sv
hdl/pe_tile.sv
tests/clock_gen.sv
tests/tile_tb.sv
